// ==== hw/line_pkg.sv ====
`default_nettype none

package line_pkg;

    // Samples counted in one phase of a cell, saturating
    typedef logic [5:0] pulse_count_t;

    localparam pulse_count_t PULSE_COUNT_MAX = 6'd63;
    localparam pulse_count_t PULSE_COUNT_ONE = 6'd1;

    // Two-flop synchronizer chain, [1] is the stable sample
    typedef logic [1:0] sync_chain_t;

    // Line idles high
    localparam sync_chain_t LINE_IDLE_CHAIN = 2'b11;

    // Increment that holds at the top value
    function automatic pulse_count_t pulse_count_inc(input pulse_count_t count);
        pulse_count_t result;
        if (count == PULSE_COUNT_MAX) begin
            result = count;
        end else begin
            result = count + PULSE_COUNT_ONE;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== hw/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

    // Assembled data byte, MSB received first
    typedef logic [7:0] byte_t;

    // Whole bytes in one frame, saturating
    typedef logic [5:0] frame_len_t;

    localparam frame_len_t FRAME_LEN_MAX = 6'd63;

    // Position of the next bit inside the byte
    typedef logic [2:0] bit_index_t;

    localparam bit_index_t BIT_INDEX_LAST = 3'd7;

    // FIFO entry is {eof, bit}
    typedef logic [1:0] fifo_entry_t;

    // Occupancy, covers a depth of 16
    typedef logic [4:0] fifo_level_t;

endpackage

`default_nettype wire

// ==== hw/pulse_bit_decoder.sv ====
`default_nettype none

module pulse_bit_decoder #(
    parameter line_pkg::pulse_count_t END_HIGH_SAMPLES = 8
) (
    input  wire  sample_clk,
    input  wire  rst_n,
    input  wire  rx_enable,
    input  wire  line_in,
    output logic bit_valid,
    output logic bit_value,
    output logic frame_end
);

    import line_pkg::*;

    typedef enum logic [1:0] {
        ST_AWAIT_LOW,
        ST_LOW_PHASE,
        ST_HIGH_PHASE
    } dec_state_t;

    dec_state_t   state;
    sync_chain_t  line_sync;
    logic         line_s;

    pulse_count_t low_cnt;
    pulse_count_t high_cnt;
    pulse_count_t low_latch;
    pulse_count_t high_next;

    logic         rise_in_low;
    logic         fall_in_high;

    // ----------------------------------------
    // Synchronizer
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            line_sync <= LINE_IDLE_CHAIN;
        end else begin
            line_sync <= {line_sync[0], line_in};
        end
    end

    assign line_s = line_sync[1];

    // Phase boundaries seen this cycle
    assign rise_in_low  = rx_enable && (state == ST_LOW_PHASE) && line_s;
    assign fall_in_high = rx_enable && (state == ST_HIGH_PHASE) && !line_s;

    assign high_next = pulse_count_inc(high_cnt);

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            state     <= ST_AWAIT_LOW;
            low_cnt   <= '0;
            high_cnt  <= '0;
            bit_valid <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            bit_valid <= 1'b0;
            frame_end <= 1'b0;

            if (!rx_enable) begin
                state    <= ST_AWAIT_LOW;
                low_cnt  <= '0;
                high_cnt <= '0;
            end else begin
                case (state)
                    ST_AWAIT_LOW: begin
                        if (!line_s) begin
                            state   <= ST_LOW_PHASE;
                            low_cnt <= PULSE_COUNT_ONE;
                        end
                    end

                    ST_LOW_PHASE: begin
                        if (rise_in_low) begin
                            state    <= ST_HIGH_PHASE;
                            high_cnt <= PULSE_COUNT_ONE;
                        end else begin
                            low_cnt <= pulse_count_inc(low_cnt);
                        end
                    end

                    ST_HIGH_PHASE: begin
                        if (fall_in_high) begin
                            // Falling edge closes the cell
                            state     <= ST_LOW_PHASE;
                            bit_valid <= 1'b1;
                            low_cnt   <= PULSE_COUNT_ONE;
                            high_cnt  <= '0;
                        end else if (high_next > END_HIGH_SAMPLES) begin
                            // Gap too long, stop cell ends the frame
                            state     <= ST_AWAIT_LOW;
                            frame_end <= 1'b1;
                            low_cnt   <= '0;
                            high_cnt  <= '0;
                        end else begin
                            high_cnt <= high_next;
                        end
                    end

                    default: begin
                        state <= ST_AWAIT_LOW;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // Low latch and bit decision
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (rise_in_low) begin
            low_latch <= low_cnt;
        end
        // Longer low phase means 0, ties give 1
        if (fall_in_high) begin
            bit_value <= !(low_latch > high_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== hw/bit_fifo.sv ====
`default_nettype none

module bit_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                   sample_clk,
    input  wire                   rst_n,
    input  wire                   bit_valid,
    input  wire                   bit_value,
    input  wire                   frame_end,
    input  wire                   pop,
    output logic                  head_bit,
    output logic                  head_eof,
    output logic                  empty,
    output logic                  overflow,
    output frame_pkg::fifo_level_t level
);

    import frame_pkg::*;

    localparam int          ADDR_W     = $clog2(FIFO_DEPTH);
    localparam fifo_level_t LEVEL_FULL = fifo_level_t'(FIFO_DEPTH);

    fifo_entry_t       mem [FIFO_DEPTH];
    fifo_entry_t       head_entry;
    fifo_entry_t       push_entry;

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;

    logic              push;
    logic              full;
    logic              push_ok;
    logic              pop_ok;

    assign push  = bit_valid | frame_end;
    assign full  = (level == LEVEL_FULL);
    assign empty = (level == '0);

    // A pop frees a slot for a push in the same cycle
    assign pop_ok  = pop && !empty;
    assign push_ok = push && (!full || pop_ok);

    assign push_entry = {frame_end, bit_valid & bit_value};

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // Show-ahead head
    assign head_entry = mem[rd_ptr];
    assign head_bit   = head_entry[0];
    assign head_eof   = head_entry[1];

    // ----------------------------------------
    // Pointers, level, overflow
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + ADDR_W'(1);
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + ADDR_W'(1);
            end

            case ({push_ok, pop_ok})
                2'b10:   level <= level + fifo_level_t'(1);
                2'b01:   level <= level - fifo_level_t'(1);
                default: level <= level;
            endcase

            // Sticky until reset
            if (push && !push_ok) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/byte_assembler.sv ====
`default_nettype none

module byte_assembler (
    input  wire                   sample_clk,
    input  wire                   rst_n,
    input  wire                   hold,
    input  wire                   head_bit,
    input  wire                   head_eof,
    input  wire                   empty,
    output logic                  pop,
    output logic                  byte_valid,
    output frame_pkg::byte_t      byte_data,
    output logic                  frame_done,
    output frame_pkg::frame_len_t frame_bytes,
    output logic                  frame_error
);

    import frame_pkg::*;

    byte_t      shift_q;
    byte_t      shift_next;
    bit_index_t bit_cnt;
    frame_len_t byte_cnt;

    logic       take_bit;
    logic       take_eof;
    logic       byte_full;

    // One entry per cycle while data is there and not held
    assign pop      = !empty && !hold;
    assign take_bit = pop && !head_eof;
    assign take_eof = pop && head_eof;

    assign shift_next = {shift_q[$bits(byte_t)-2:0], head_bit};
    assign byte_full  = (bit_cnt == BIT_INDEX_LAST);

    // ----------------------------------------
    // Counters and strobes
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            byte_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            byte_valid <= take_bit && byte_full;
            frame_done <= take_eof;

            if (take_eof) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
            end else if (take_bit) begin
                // Wraps to zero after the eighth bit
                bit_cnt <= bit_cnt + bit_index_t'(1);
                if (byte_full && (byte_cnt != FRAME_LEN_MAX)) begin
                    byte_cnt <= byte_cnt + frame_len_t'(1);
                end
            end
        end
    end

    // ----------------------------------------
    // Data path
    // ----------------------------------------

    always_ff @(posedge sample_clk) begin
        if (take_bit) begin
            shift_q <= shift_next;
        end

        if (take_bit && byte_full) begin
            byte_data <= shift_next;
        end

        // Leftover bits are dropped and flagged
        if (take_eof) begin
            frame_bytes <= byte_cnt;
            frame_error <= (bit_cnt != '0);
        end
    end

endmodule

`default_nettype wire

// ==== hw/serial_rx_top.sv ====
`default_nettype none

module serial_rx_top #(
    parameter line_pkg::pulse_count_t END_HIGH_SAMPLES = 8,
    parameter int                     FIFO_DEPTH       = 16
) (
    input  wire                    sample_clk,
    input  wire                    rst_n,
    input  wire                    rx_enable,
    input  wire                    hold,
    input  wire                    line_in,
    output logic                   byte_valid,
    output frame_pkg::byte_t       byte_data,
    output logic                   frame_done,
    output frame_pkg::frame_len_t  frame_bytes,
    output logic                   frame_error,
    output logic                   overflow,
    output frame_pkg::fifo_level_t fifo_level
);

    // Decoder to FIFO
    logic bit_valid;
    logic bit_value;
    logic frame_end;

    // FIFO to assembler
    logic head_bit;
    logic head_eof;
    logic empty;
    logic pop;

    pulse_bit_decoder #(
        .END_HIGH_SAMPLES(END_HIGH_SAMPLES)
    ) pulse_bit_decoder_inst (
        .sample_clk(sample_clk),
        .rst_n     (rst_n),
        .rx_enable (rx_enable),
        .line_in   (line_in),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .frame_end (frame_end)
    );

    bit_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) bit_fifo_inst (
        .sample_clk(sample_clk),
        .rst_n     (rst_n),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .frame_end (frame_end),
        .pop       (pop),
        .head_bit  (head_bit),
        .head_eof  (head_eof),
        .empty     (empty),
        .overflow  (overflow),
        .level     (fifo_level)
    );

    byte_assembler byte_assembler_inst (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .hold       (hold),
        .head_bit   (head_bit),
        .head_eof   (head_eof),
        .empty      (empty),
        .pop        (pop),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_done (frame_done),
        .frame_bytes(frame_bytes),
        .frame_error(frame_error)
    );

endmodule

`default_nettype wire

// ==== tests/tb_serial_rx_tasks.svh ====
`ifndef TB_SERIAL_RX_TASKS_SVH
`define TB_SERIAL_RX_TASKS_SVH

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
endtask

task automatic check_value(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        fail_run($sformatf("** Error: %s expected %0h actual %0h",
                           test_name, expected, actual));
    end
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Phase length from 1 to 7 samples
function automatic int rand_phase();
    logic [31:0] r;
    r = lcg_next();
    return int'((r >> 16) % 32'd7) + 1;
endfunction

// ----------------------------------------
// Line encoder
// ----------------------------------------

task automatic drive_line(input logic value, input int samples);
    repeat (samples) begin
        @(negedge sample_clk);
        line_in = value;
    end
endtask

task automatic drive_cell(input int low_len, input int high_len);
    drive_line(1'b0, low_len);
    drive_line(1'b1, high_len);
endtask

// Data bits MSB first, then stop cell and gap
task automatic send_frame(input logic [31:0] bits, input int count);
    for (int i = count - 1; i >= 0; i--) begin
        if (bits[i]) begin
            drive_cell(SHORT_PHASE, LONG_PHASE);
        end else begin
            drive_cell(LONG_PHASE, SHORT_PHASE);
        end
    end
    drive_cell(STOP_LOW, GAP_HIGH);
endtask

// ----------------------------------------
// Monitor and result checks
// ----------------------------------------

task automatic monitor_outputs();
    forever begin
        @(negedge sample_clk);
        if (byte_valid) begin
            byte_q.push_back(byte_data);
        end
        if (frame_done) begin
            frame_q.push_back({frame_error, frame_bytes});
        end
    end
endtask

// Bytes are packed MSB first in data, one frame report at most
task automatic expect_result(input string test_name, input logic [31:0] data,
                             input int bytes, input int frames, input logic exp_error);
    int         cycles;
    logic [6:0] report;
    cycles = 0;
    while ((byte_q.size() < bytes || frame_q.size() < frames) && cycles < WAIT_LIMIT) begin
        @(posedge sample_clk);
        cycles++;
    end
    if (byte_q.size() < bytes || frame_q.size() < frames) begin
        fail_run($sformatf("%s timed out waiting for %0d bytes and %0d frames",
                           test_name, bytes, frames));
    end else begin
        check_value({test_name, " byte count"}, 32'(bytes), 32'(byte_q.size()));
        check_value({test_name, " frame count"}, 32'(frames), 32'(frame_q.size()));
        for (int i = bytes - 1; i >= 0; i--) begin
            check_value({test_name, " byte"}, 32'(data[8*i +: 8]), 32'(byte_q.pop_front()));
        end
        if (frames > 0) begin
            report = frame_q.pop_front();
            check_value({test_name, " frame_bytes"}, 32'(bytes), 32'(report[5:0]));
            check_value({test_name, " frame_error"}, 32'(exp_error), 32'(report[6]));
        end
    end
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------

task automatic test_reset();
    apply_reset();
    repeat (20) begin
        @(negedge sample_clk);
        check_value("reset outputs", 32'd0,
                    32'({byte_valid, frame_done, overflow, fifo_level}));
    end
endtask

task automatic test_single_byte();
    send_frame(32'hA5, 8);
    expect_result("single_byte", 32'hA5, 1, 1, 1'b0);
endtask

task automatic test_random_frame();
    logic [31:0] data;
    logic        tie_pending;
    int          a;
    int          b;
    int          lo;
    int          hi;
    data        = lcg_next() >> 8;
    tie_pending = 1'b1;
    for (int i = 23; i >= 0; i--) begin
        a = rand_phase();
        b = rand_phase();
        // First one-bit always ties, later ones now and then
        if (data[i] && (tie_pending || a < 3)) begin
            b           = a;
            tie_pending = 1'b0;
        end else if (a == b) begin
            b = a % 7 + 1;
        end
        lo = (a < b) ? a : b;
        hi = a + b - lo;
        if (data[i]) begin
            drive_cell(lo, hi);
        end else begin
            drive_cell(hi, lo);
        end
    end
    drive_cell(STOP_LOW, GAP_HIGH);
    expect_result("random_frame", data, 3, 1, 1'b0);
endtask

task automatic test_partial_frame();
    send_frame(32'({8'h3C, 3'b101}), 11);
    expect_result("partial_frame", 32'h3C, 1, 1, 1'b1);
    send_frame(32'h96, 8);
    expect_result("after_partial", 32'h96, 1, 1, 1'b0);
endtask

// 20 bits and a frame end into 16 entries
task automatic test_hold_overflow();
    @(negedge sample_clk);
    hold = 1'b1;
    send_frame(32'({8'hC3, 8'h5A, 4'b1001}), 20);
    // Frame end was pushed well inside the gap
    check_value("hold_overflow overflow", 32'd1, 32'(overflow));
    check_value("hold_overflow fifo_level", 32'd16, 32'(fifo_level));
    hold = 1'b0;
    expect_result("hold_overflow", 32'hC35A, 2, 0, 1'b0);
    @(negedge sample_clk);
    check_value("hold_overflow sticky", 32'd1, 32'(overflow));
    apply_reset();
    check_value("hold_overflow reset overflow", 32'd0, 32'(overflow));
    check_value("hold_overflow reset fifo_level", 32'd0, 32'(fifo_level));
endtask

task automatic test_rx_disabled();
    @(negedge sample_clk);
    rx_enable = 1'b0;
    send_frame(32'h81, 8);
    repeat (QUIET_CYCLES) begin
        @(posedge sample_clk);
        check_value("rx_disabled bytes", 32'd0, 32'(byte_q.size()));
        check_value("rx_disabled frames", 32'd0, 32'(frame_q.size()));
    end
    @(negedge sample_clk);
    rx_enable = 1'b1;
    send_frame(32'h7E, 8);
    expect_result("rx_enabled", 32'h7E, 1, 1, 1'b0);
endtask

`endif

// ==== tests/tb_serial_rx_top.sv ====
`default_nettype none

module tb_serial_rx_top;

    // Cell phase lengths in samples
    localparam int SHORT_PHASE  = 2;
    localparam int LONG_PHASE   = 6;
    localparam int STOP_LOW     = 2;
    localparam int GAP_HIGH     = 14;

    localparam int WAIT_LIMIT   = 600;
    localparam int QUIET_CYCLES = 100;

    logic        sample_clk;
    logic        rst_n;
    logic        rx_enable;
    logic        hold;
    logic        line_in;

    logic        byte_valid;
    logic [7:0]  byte_data;
    logic        frame_done;
    logic [5:0]  frame_bytes;
    logic        frame_error;
    logic        overflow;
    logic [4:0]  fifo_level;

    // Frame entries are {frame_error, frame_bytes}
    logic [7:0]  byte_q[$];
    logic [6:0]  frame_q[$];
    logic [31:0] lcg_state;

    serial_rx_top serial_rx_top_inst (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .rx_enable  (rx_enable),
        .hold       (hold),
        .line_in    (line_in),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_done (frame_done),
        .frame_bytes(frame_bytes),
        .frame_error(frame_error),
        .overflow   (overflow),
        .fifo_level (fifo_level)
    );

    initial begin
        sample_clk = 1'b0;
        forever begin
            #50;
            sample_clk = ~sample_clk;
        end
    end

    // ----------------------------------------
    // Reset and test sequence
    // ----------------------------------------

    // Five rising edges with reset low
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge sample_clk);
        rst_n = 1'b1;
    endtask

    `include "tb_serial_rx_tasks.svh"

    initial begin
        monitor_outputs();
    end

    initial begin
        rst_n     = 1'b0;
        rx_enable = 1'b1;
        hold      = 1'b0;
        line_in   = 1'b1;
        lcg_state = 32'h3844;

        test_reset();
        test_single_byte();
        test_random_frame();
        test_partial_frame();
        test_hold_overflow();
        test_rx_disabled();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== serial_rx_top.f ====
+incdir+tests
hw/line_pkg.sv
hw/frame_pkg.sv
hw/pulse_bit_decoder.sv
hw/bit_fifo.sv
hw/byte_assembler.sv
hw/serial_rx_top.sv
tests/tb_serial_rx_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the serial receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f serial_rx_top.f --top-module tb_serial_rx_top

# A failing run still leaves its log for the search below
./obj_dir/Vtb_serial_rx_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
